// ==== bench/tpu_tb.sv ====
// directed testbench for tpu_top with reference product, job tasks, timeout and verdict
`timescale 1ns/10ps

module tpu_tb
        import tpu_pkg::*;
();

        localparam int NUM_JOBS       = 10;
        // load with gaps, drain, stalled write, done, plus margin
        localparam int JOB_CYCLES     = 64;
        localparam int TIMEOUT_CYCLES = NUM_JOBS * JOB_CYCLES + 20;

        logic clk;
        logic rst_n;
        logic in_valid;
        vec_t a;
        vec_t b;
        logic out_ready;
        logic in_ready;
        vec_t out;
        logic out_valid;
        logic done;

        logic [31:0] rand_state;
        int          cycle_count;
        elem_t       mat_a [ARRAY_DIM][ARRAY_DIM];
        elem_t       mat_b [ARRAY_DIM][ARRAY_DIM];
        elem_t       exp_c [ARRAY_DIM][ARRAY_DIM];

        tpu_top u_tpu_top (
                .clk       (clk),
                .rst_n     (rst_n),
                .in_valid  (in_valid),
                .a         (a),
                .b         (b),
                .out_ready (out_ready),
                .in_ready  (in_ready),
                .out       (out),
                .out_valid (out_valid),
                .done      (done)
        );

        bind tpu_top tpu_tb_asserts u_asserts (
                .clk       (clk),
                .rst_n     (rst_n),
                .in_ready  (in_ready),
                .out_valid (out_valid),
                .out_ready (out_ready),
                .out       (out),
                .done      (done)
        );

        always #10 clk = ~clk;

        // ==============================
        // helpers
        // ==============================
        task automatic abort_run();
                $display("RESULT: FAIL");
                $fatal(1, "simulation stopped after a failure");
        endtask

        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count > TIMEOUT_CYCLES) begin
                        $display("timeout: the DUT did not finish within %0d cycles",
                                 TIMEOUT_CYCLES);
                        abort_run();
                end
        end

        always @(negedge clk) begin
                if (u_tpu_top.u_asserts.failed) begin
                        $display("a bound assertion on the tpu_top handshakes failed");
                        abort_run();
                end
        end

        function automatic logic [31:0] next_rand();
                rand_state = rand_state * 32'd1664525 + 32'd1013904223;
                return rand_state;
        endfunction

        // one element of A x B wrapped to the element width
        function automatic elem_t ref_elem(input int i, input int j);
                int sum;
                sum = 0;
                for (int k = 0; k < ARRAY_DIM; k++) begin
                        sum = sum + int'(mat_a[i][k]) * int'(mat_b[k][j]);
                end
                return elem_t'(sum % 256);
        endfunction

        task automatic expect_value(input string name, input logic [31:0] got,
                                    input logic [31:0] exp);
                assert (got === exp) else begin
                        $display("error: %s got %h expected %h", name, got, exp);
                        abort_run();
                end
        endtask

        task automatic fill_random();
                logic [31:0] rnd;
                for (int i = 0; i < ARRAY_DIM; i++) begin
                        for (int j = 0; j < ARRAY_DIM; j++) begin
                                rnd = next_rand();
                                mat_a[i][j] = rnd[31:24];
                                rnd = next_rand();
                                mat_b[i][j] = rnd[31:24];
                        end
                end
        endtask

        task automatic expect_product();
                for (int i = 0; i < ARRAY_DIM; i++) begin
                        for (int j = 0; j < ARRAY_DIM; j++) begin
                                exp_c[i][j] = ref_elem(i, j);
                        end
                end
        endtask

        // ==============================
        // job tasks
        // ==============================
        // beat k carries column k of A and row k of B
        task automatic send_job(input bit gaps);
                logic [31:0] rnd;
                bit          accepted;
                for (int k = 0; k < ARRAY_DIM; k++) begin
                        if (gaps) begin
                                rnd = next_rand();
                                repeat (rnd[31:30]) begin
                                        @(posedge clk);
                                        #1;
                                end
                        end
                        in_valid = 1'b1;
                        for (int n = 0; n < ARRAY_DIM; n++) begin
                                a[n] = mat_a[n][k];
                                b[n] = mat_b[k][n];
                        end
                        accepted = 1'b0;
                        while (!accepted) begin
                                @(negedge clk);
                                accepted = in_ready;
                                @(posedge clk);
                                #1;
                        end
                        in_valid = 1'b0;
                end
        endtask

        task automatic collect_rows(input bit stalls);
                logic [31:0] rnd;
                int          rows;
                int          stall_run;
                vec_t        row_exp;
                rows = 0;
                stall_run = 0;
                while (rows < ARRAY_DIM) begin
                        @(posedge clk);
                        #1;
                        rnd = next_rand();
                        // stalls are capped so a row always gets through
                        if (stalls && stall_run < 3 && rnd[31]) begin
                                out_ready = 1'b0;
                                stall_run++;
                        end else begin
                                out_ready = 1'b1;
                                stall_run = 0;
                        end
                        @(negedge clk);
                        expect_value("done", done, 1'b0);
                        if (out_valid && out_ready) begin
                                for (int j = 0; j < ARRAY_DIM; j++) begin
                                        row_exp[j] = exp_c[rows][j];
                                end
                                expect_value($sformatf("out row %0d", rows), out, row_exp);
                                rows++;
                        end
                end
                @(posedge clk);
                #1;
                out_ready = 1'b0;
                // done right after the final row and no extra row
                @(negedge clk);
                expect_value("done", done, 1'b1);
                expect_value("out_valid", out_valid, 1'b0);
                @(posedge clk);
                #1;
                @(negedge clk);
                expect_value("done", done, 1'b0);
                expect_value("in_ready", in_ready, 1'b1);
                @(posedge clk);
                #1;
        endtask

        // ==============================
        // tests
        // ==============================
        task automatic test_reset();
                @(negedge clk);
                expect_value("in_ready", in_ready, 1'b1);
                expect_value("out_valid", out_valid, 1'b0);
                expect_value("done", done, 1'b0);
                @(posedge clk);
                #1;
        endtask

        task automatic test_identity();
                fill_random();
                for (int i = 0; i < ARRAY_DIM; i++) begin
                        for (int j = 0; j < ARRAY_DIM; j++) begin
                                mat_a[i][j] = (i == j) ? 8'h01 : 8'h00;
                                exp_c[i][j] = mat_b[i][j];
                        end
                end
                send_job(1'b0);
                collect_rows(1'b0);
        endtask

        task automatic test_random(input bit gaps, input bit stalls);
                fill_random();
                expect_product();
                send_job(gaps);
                collect_rows(stalls);
        endtask

        // all ones in both matrices so every sum wraps
        task automatic test_wrap();
                for (int i = 0; i < ARRAY_DIM; i++) begin
                        for (int j = 0; j < ARRAY_DIM; j++) begin
                                mat_a[i][j] = 8'hff;
                                mat_b[i][j] = 8'hff;
                        end
                end
                expect_product();
                send_job(1'b0);
                collect_rows(1'b0);
        endtask

        initial begin
                clk = 1'b0;
                rst_n = 1'b0;
                in_valid = 1'b0;
                a = '0;
                b = '0;
                out_ready = 1'b0;
                cycle_count = 0;
                rand_state = 32'h4d124d7e;

                repeat (3) @(posedge clk);
                #1;
                rst_n = 1'b1;

                test_reset();
                test_identity();
                test_wrap();
                repeat (3) test_random(1'b0, 1'b0);
                repeat (3) test_random(1'b1, 1'b1);
                // second job back to back must not see the first
                test_random(1'b0, 1'b1);
                test_random(1'b1, 1'b0);

                if (u_tpu_top.u_asserts.failed) begin
                        $display("a bound assertion on the tpu_top handshakes failed");
                        abort_run();
                end else begin
                        $display("RESULT: PASS");
                        $finish;
                end
        end

endmodule

// ==== bench/tpu_tb_asserts.sv ====
// concurrent assertions on the tpu_top input and output handshakes and the done pulse
`timescale 1ns/10ps

module tpu_tb_asserts
        import tpu_pkg::*;
(
        input logic clk,
        input logic rst_n,
        input logic in_ready,
        input logic out_valid,
        input logic out_ready,
        input vec_t out,
        input logic done
);

        logic hold_failed = 1'b0;
        logic overlap_failed = 1'b0;
        logic pulse_failed = 1'b0;
        logic failed;

        assign failed = hold_failed || overlap_failed || pulse_failed;

        // ==============================
        // output back-pressure
        // ==============================
        property p_out_hold;
                @(posedge clk) disable iff (!rst_n)
                (out_valid && !out_ready) |=> (out_valid && $stable(out));
        endproperty

        a_out_hold: assert property (p_out_hold)
                else begin
                        $error("out_valid or out changed while the consumer stalled");
                        hold_failed = 1'b1;
                end

        // input and output phases never overlap
        a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
                !(in_ready && out_valid))
                else begin
                        $error("in_ready and out_valid were high in the same cycle");
                        overlap_failed = 1'b1;
                end

        // done is a single-cycle pulse
        a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
                done |=> !done)
                else begin
                        $error("done stayed high for more than one cycle");
                        pulse_failed = 1'b1;
                end

endmodule

// ==== logic/tpu_ctrl.sv ====
// job FSM with input and output handshakes and the step, feed and clear strobes
`timescale 1ns/10ps

module tpu_ctrl
        import tpu_pkg::*;
(
        input  logic       clk,
        input  logic       rst_n,
        input  logic       in_valid,
        input  logic       out_ready,
        input  logic       load_last,
        input  logic       drain_last,
        input  logic       write_last,
        output tpu_state_t state,
        output logic       in_ready,
        output logic       out_valid,
        output logic       done,
        output logic       step,
        output logic       feed,
        output logic       clear
);

        tpu_state_t state_next;
        logic       in_beat;
        logic       out_beat;

        // ==============================
        // handshakes
        // ==============================
        assign in_ready  = (state == IDLE) || (state == LOAD);
        assign out_valid = (state == WRITE);
        assign done      = (state == DONE);

        assign in_beat  = in_valid && in_ready;
        assign out_beat = out_valid && out_ready;

        // ==============================
        // array strobes
        // ==============================
        // array moves on accepted beats and on every drain cycle
        assign step = in_beat || (state == DRAIN);
        assign feed = in_beat;

        // idle without a beat wipes the skew lines and accumulators
        assign clear = (state == IDLE) && !in_beat;

        // ==============================
        // state machine
        // ==============================
        always_comb begin
                state_next = state;
                unique case (state)
                        IDLE: begin
                                if (in_beat) begin
                                        // a single-beat job skips load
                                        state_next = load_last ? DRAIN : LOAD;
                                end
                        end
                        LOAD: begin
                                if (load_last) begin
                                        state_next = DRAIN;
                                end
                        end
                        DRAIN: begin
                                if (drain_last) begin
                                        state_next = WRITE;
                                end
                        end
                        WRITE: begin
                                if (out_beat && write_last) begin
                                        state_next = DONE;
                                end
                        end
                        DONE: begin
                                state_next = IDLE;
                        end
                        default: begin
                                state_next = IDLE;
                        end
                endcase
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state <= IDLE;
                end else begin
                        state <= state_next;
                end
        end

endmodule

// ==== logic/tpu_pe.sv ====
// processing element with forwarding registers and a wrapping multiply-accumulate
`timescale 1ns/10ps

module tpu_pe
        import tpu_pkg::*;
(
        input  logic  clk,
        input  logic  rst_n,
        input  logic  step,
        input  logic  clear,
        input  elem_t a_in,
        input  elem_t b_in,
        output elem_t a_out,
        output elem_t b_out,
        output elem_t acc
);

        elem_t prod;

        // product kept to DATA_WIDTH bits, so the sum wraps as well
        assign prod = elem_t'(a_in * b_in);

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        acc   <= '0;
                        a_out <= '0;
                        b_out <= '0;
                end else if (clear) begin
                        acc   <= '0;
                        a_out <= '0;
                        b_out <= '0;
                end else if (step) begin
                        acc   <= acc + prod;
                        // operands move on to the right and down
                        a_out <= a_in;
                        b_out <= b_in;
                end
        end

endmodule

// ==== logic/tpu_pe_array.sv ====
// systolic grid of processing elements and the output row selector
`timescale 1ns/10ps

module tpu_pe_array
        import tpu_pkg::*;
(
        input  logic clk,
        input  logic rst_n,
        input  logic step,
        input  logic clear,
        input  vec_t a_skew,
        input  vec_t b_skew,
        input  cnt_t row_sel,
        output vec_t row_out
);

        // horizontal links carry A, vertical links carry B
        wire elem_t a_link   [ARRAY_DIM][ARRAY_DIM+1];
        wire elem_t b_link   [ARRAY_DIM+1][ARRAY_DIM];
        wire elem_t acc_grid [ARRAY_DIM][ARRAY_DIM];

        // ==============================
        // edges
        // ==============================
        for (genvar e = 0; e < ARRAY_DIM; e++) begin : g_edge
                assign a_link[e][0] = a_skew[e];
                assign b_link[0][e] = b_skew[e];
        end

        // ==============================
        // grid
        // ==============================
        for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_row
                for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_col
                        tpu_pe u_pe (
                                .clk   (clk),
                                .rst_n (rst_n),
                                .step  (step),
                                .clear (clear),
                                .a_in  (a_link[r][c]),
                                .b_in  (b_link[r][c]),
                                .a_out (a_link[r][c+1]),
                                .b_out (b_link[r+1][c]),
                                .acc   (acc_grid[r][c])
                        );
                end
        end

        // row of C picked by the write count
        always_comb begin
                row_out = '0;
                for (int i = 0; i < ARRAY_DIM; i++) begin
                        if (row_sel == cnt_t'(i)) begin
                                for (int j = 0; j < ARRAY_DIM; j++) begin
                                        row_out[j] = acc_grid[i][j];
                                end
                        end
                end
        end

endmodule

// ==== logic/tpu_phase_counter.sv ====
// step and beat counter for each phase, with the last-cycle flags of each phase
`timescale 1ns/10ps

module tpu_phase_counter
        import tpu_pkg::*;
(
        input  logic       clk,
        input  logic       rst_n,
        input  tpu_state_t state,
        input  logic       step,
        input  logic       out_ready,
        output cnt_t       count,
        output logic       load_last,
        output logic       drain_last,
        output logic       write_last
);

        logic in_load;
        logic inc;
        logic phase_end;

        // the first beat is taken in idle, so idle and load share one count
        assign in_load = (state == IDLE) || (state == LOAD);

        // write advances per output beat, the rest per array step
        assign inc = (state == WRITE) ? out_ready : step;

        // ==============================
        // end-of-phase flags
        // ==============================
        assign load_last  = in_load && step && (count == cnt_t'(ARRAY_DIM - 1));
        assign drain_last = (state == DRAIN) && (count == cnt_t'(DRAIN_STEPS - 1));
        assign write_last = (state == WRITE) && out_ready &&
                            (count == cnt_t'(ARRAY_DIM - 1));

        // every phase exit lines up with one of these
        assign phase_end = load_last || drain_last || write_last || (state == DONE);

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        count <= '0;
                end else if (phase_end) begin
                        count <= '0;
                end else if (inc) begin
                        count <= count + 1'b1;
                end
        end

endmodule

// ==== logic/tpu_pkg.sv ====
// array size, element and vector types, controller state type and phase lengths
package tpu_pkg;

        // ==============================
        // sizes
        // ==============================
        localparam int ARRAY_DIM  = 4;
        localparam int DATA_WIDTH = 8;

        // free-running steps after the last input beat
        localparam int DRAIN_STEPS = 2 * ARRAY_DIM;

        // holds counts up to DRAIN_STEPS
        localparam int CNT_WIDTH = $clog2(DRAIN_STEPS + 1);

        // ==============================
        // types
        // ==============================
        typedef logic [DATA_WIDTH-1:0] elem_t;

        // lane 0 in the most significant byte
        typedef elem_t [0:ARRAY_DIM-1] vec_t;

        typedef logic [CNT_WIDTH-1:0] cnt_t;

        // job sequence
        typedef enum logic [2:0] {
                IDLE,
                LOAD,
                DRAIN,
                WRITE,
                DONE
        } tpu_state_t;

endpackage

// ==== logic/tpu_skew_buffer.sv ====
// triangular skew buffer, lane i delayed by i steps before the array edge
`timescale 1ns/10ps

module tpu_skew_buffer
        import tpu_pkg::*;
(
        input  logic clk,
        input  logic rst_n,
        input  logic step,
        input  logic feed,
        input  logic clear,
        input  vec_t lanes_in,
        output vec_t lanes_out
);

        vec_t       lanes_gated;
        wire elem_t tail [ARRAY_DIM];

        // zeros flow in once loading is over
        assign lanes_gated = feed ? lanes_in : '0;

        // lane 0 has no delay
        assign tail[0] = lanes_gated[0];

        for (genvar g = 1; g < ARRAY_DIM; g++) begin : g_lane
                elem_t line [g];

                always_ff @(posedge clk or negedge rst_n) begin
                        if (!rst_n) begin
                                for (int k = 0; k < g; k++) begin
                                        line[k] <= '0;
                                end
                        end else if (clear) begin
                                for (int k = 0; k < g; k++) begin
                                        line[k] <= '0;
                                end
                        end else if (step) begin
                                line[0] <= lanes_gated[g];
                                for (int k = 1; k < g; k++) begin
                                        line[k] <= line[k-1];
                                end
                        end
                end

                assign tail[g] = line[g-1];
        end

        always_comb begin
                for (int n = 0; n < ARRAY_DIM; n++) begin
                        lanes_out[n] = tail[n];
                end
        end

endmodule

// ==== logic/tpu_top.sv ====
// matrix-multiply engine top with controller, phase counter, skew buffers and PE grid
`timescale 1ns/10ps

module tpu_top
        import tpu_pkg::*;
(
        input  logic clk,
        input  logic rst_n,
        input  logic in_valid,
        input  vec_t a,
        input  vec_t b,
        input  logic out_ready,
        output logic in_ready,
        output vec_t out,
        output logic out_valid,
        output logic done
);

        tpu_state_t state;
        logic       step;
        logic       feed;
        logic       clear;
        cnt_t       count;
        logic       load_last;
        logic       drain_last;
        logic       write_last;
        vec_t       a_skew;
        vec_t       b_skew;

        // ==============================
        // control
        // ==============================
        tpu_ctrl u_ctrl (
                .clk        (clk),
                .rst_n      (rst_n),
                .in_valid   (in_valid),
                .out_ready  (out_ready),
                .load_last  (load_last),
                .drain_last (drain_last),
                .write_last (write_last),
                .state      (state),
                .in_ready   (in_ready),
                .out_valid  (out_valid),
                .done       (done),
                .step       (step),
                .feed       (feed),
                .clear      (clear)
        );

        tpu_phase_counter u_phase_counter (
                .clk        (clk),
                .rst_n      (rst_n),
                .state      (state),
                .step       (step),
                .out_ready  (out_ready),
                .count      (count),
                .load_last  (load_last),
                .drain_last (drain_last),
                .write_last (write_last)
        );

        // ==============================
        // datapath
        // ==============================
        tpu_skew_buffer u_skew_a (
                .clk       (clk),
                .rst_n     (rst_n),
                .step      (step),
                .feed      (feed),
                .clear     (clear),
                .lanes_in  (a),
                .lanes_out (a_skew)
        );

        tpu_skew_buffer u_skew_b (
                .clk       (clk),
                .rst_n     (rst_n),
                .step      (step),
                .feed      (feed),
                .clear     (clear),
                .lanes_in  (b),
                .lanes_out (b_skew)
        );

        // output row comes straight off the accumulators
        tpu_pe_array u_pe_array (
                .clk     (clk),
                .rst_n   (rst_n),
                .step    (step),
                .clear   (clear),
                .a_skew  (a_skew),
                .b_skew  (b_skew),
                .row_sel (count),
                .row_out (out)
        );

endmodule

// ==== sim.f ====
logic/tpu_pkg.sv
logic/tpu_pe.sv
logic/tpu_pe_array.sv
logic/tpu_skew_buffer.sv
logic/tpu_phase_counter.sv
logic/tpu_ctrl.sv
logic/tpu_top.sv
bench/tpu_tb_asserts.sv
bench/tpu_tb.sv
